/* source/rv_params.svh */
// width and register-count macros for the decode stage, included by the packages and the RTL
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

//////////////////////////////
// datapath
//////////////////////////////

// data width of the integer datapath
`define XLEN 32

//////////////////////////////
// register file
//////////////////////////////

// architectural integer registers
`define NUM_REGS 32
// bits needed to name one register
`define REG_IDX_W 5
// x0, hardwired to zero
`define ZERO_REG {`REG_IDX_W{1'b0}}

// one-bit control levels
`define TRUE 1'b1
`define FALSE 1'b0

`endif

/* source/isa_pkg.sv */
// RV32IM encoding types, imported by the decoder to match opcode, funct3 and funct7
`include "rv_params.svh"

package isa_pkg;

	//////////////////////////////
	// major opcodes
	//////////////////////////////

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// funct3 of the integer ALU ops, shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	// SRL and SRA, told apart by funct7
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct3 of the multiply group under FUNCT7_MULDIV
	localparam logic [2:0] F3_MUL    = 3'b000;
	localparam logic [2:0] F3_MULH   = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU  = 3'b011;

	// loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	// stores
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// conditional branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// CSR access under SYSTEM
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;

	// funct7 groups
	localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// R-type field layout, msb first
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`REG_IDX_W-1:0] rs2;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [`REG_IDX_W-1:0] rd;
		opcode_e               opcode;
	} inst_t;

	// wait for interrupt, used as the halt word
	localparam logic [31:0] WFI_INST = 32'h10500073;

endpackage

/* source/pipe_pkg.sv */
// pipeline packet and control-select types shared by the decode stage and its neighbours
`include "rv_params.svh"

package pipe_pkg;

	import isa_pkg::*;

	//////////////////////////////
	// datapath selects
	//////////////////////////////

	// alu operand a source
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1,
		OPA_IS_ZERO = 2'h2
	} opa_sel_e;

	// alu operand b source, immediates built in execute
	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_e;

	// destination register mux select
	typedef enum logic {
		DEST_RD   = 1'b0,
		DEST_NONE = 1'b1
	} dest_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
		ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH,
		ALU_MULHSU, ALU_MULHU
	} alu_func_e;

	// execution unit that takes the op after dispatch
	typedef enum logic [2:0] {
		ALU, BR, LD, ST, MULT
	} ex_channel_e;

	//////////////////////////////
	// packets
	//////////////////////////////

	typedef struct packed {
		logic             valid;
		inst_t            inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc;
	} if_id_packet_t;

	// one retiring result from the reorder buffer
	typedef struct packed {
		logic                  valid;
		logic [`REG_IDX_W-1:0] dest_reg_idx;
		logic [`XLEN-1:0]      dest_reg_value;
	} retire_packet_t;

	typedef struct packed {
		logic                  valid;
		inst_t                 inst;
		logic [`XLEN-1:0]      pc;
		logic [`XLEN-1:0]      npc;
		logic [`XLEN-1:0]      rs1_value;
		logic [`XLEN-1:0]      rs2_value;
		opa_sel_e              opa_select;
		opb_sel_e              opb_select;
		alu_func_e             alu_func;
		logic [`REG_IDX_W-1:0] dest_reg_idx;
		logic                  rd_mem;
		logic                  wr_mem;
		logic                  cond_branch;
		logic                  uncond_branch;
		logic                  csr_op;
		logic                  halt;
		logic                  illegal;
		ex_channel_e           ex_channel;
	} id_ex_packet_t;

endpackage

/* source/decoder.sv */
// combinational RV32IM decoder that turns one fetched word into datapath control fields
`timescale 1ns/1ns
`include "rv_params.svh"

module decoder import isa_pkg::*, pipe_pkg::*; (
	input  if_id_packet_t if_packet,
	output opa_sel_e      opa_select,
	output opb_sel_e      opb_select,
	output dest_sel_e     dest_sel,
	output alu_func_e     alu_func,
	output logic          rd_mem,
	output logic          wr_mem,
	output logic          cond_branch,
	output logic          uncond_branch,
	output logic          csr_op,
	output logic          halt,
	output logic          illegal,
	output logic          valid,
	output ex_channel_e   ex_channel
);

	inst_t inst;

	assign inst = if_packet.inst;
	// halt stays valid, illegal words drop out
	assign valid = if_packet.valid & ~illegal;

	always_comb begin
		// no-op defaults, kept for an invalid input
		opa_select    = OPA_IS_RS1;
		opb_select    = OPB_IS_RS2;
		dest_sel      = DEST_NONE;
		alu_func      = ALU_ADD;
		rd_mem        = `FALSE;
		wr_mem        = `FALSE;
		cond_branch   = `FALSE;
		uncond_branch = `FALSE;
		csr_op        = `FALSE;
		halt          = `FALSE;
		illegal       = `FALSE;
		ex_channel    = ALU;

		if (if_packet.valid) begin
			case (inst.opcode)
				OPC_LUI: begin
					dest_sel   = DEST_RD;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_U_IMM;
				end
				OPC_AUIPC: begin
					dest_sel   = DEST_RD;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_U_IMM;
				end
				OPC_JAL: begin
					dest_sel      = DEST_RD;
					opa_select    = OPA_IS_PC;
					opb_select    = OPB_IS_J_IMM;
					uncond_branch = `TRUE;
					ex_channel    = BR;
				end
				OPC_JALR: begin
					// jalr defines funct3 zero only
					if (inst.funct3 == 3'b000) begin
						dest_sel      = DEST_RD;
						opb_select    = OPB_IS_I_IMM;
						uncond_branch = `TRUE;
						ex_channel    = BR;
					end else begin
						illegal = `TRUE;
					end
				end
				OPC_BRANCH: begin
					case (inst.funct3)
						F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
							opa_select  = OPA_IS_PC;
							opb_select  = OPB_IS_B_IMM;
							cond_branch = `TRUE;
							ex_channel  = BR;
						end
						default: illegal = `TRUE;
					endcase
				end
				OPC_LOAD: begin
					case (inst.funct3)
						F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: begin
							dest_sel   = DEST_RD;
							opb_select = OPB_IS_I_IMM;
							rd_mem     = `TRUE;
							ex_channel = LD;
						end
						default: illegal = `TRUE;
					endcase
				end
				OPC_STORE: begin
					case (inst.funct3)
						F3_SB, F3_SH, F3_SW: begin
							opb_select = OPB_IS_S_IMM;
							wr_mem     = `TRUE;
							ex_channel = ST;
						end
						default: illegal = `TRUE;
					endcase
				end
				OPC_OP_IMM: begin
					dest_sel   = DEST_RD;
					opb_select = OPB_IS_I_IMM;
					case (inst.funct3)
						F3_ADD:  alu_func = ALU_ADD;
						F3_SLT:  alu_func = ALU_SLT;
						F3_SLTU: alu_func = ALU_SLTU;
						F3_XOR:  alu_func = ALU_XOR;
						F3_OR:   alu_func = ALU_OR;
						F3_AND:  alu_func = ALU_AND;
						// shift amount sits in rs2, funct7 picks the shift kind
						F3_SLL:  begin
							if (inst.funct7 == FUNCT7_BASE) alu_func = ALU_SLL;
							else illegal = `TRUE;
						end
						default: begin
							if (inst.funct7 == FUNCT7_BASE) alu_func = ALU_SRL;
							else if (inst.funct7 == FUNCT7_ALT) alu_func = ALU_SRA;
							else illegal = `TRUE;
						end
					endcase
				end
				OPC_OP: begin
					dest_sel = DEST_RD;
					case (inst.funct7)
						FUNCT7_BASE: begin
							case (inst.funct3)
								F3_ADD:  alu_func = ALU_ADD;
								F3_SLL:  alu_func = ALU_SLL;
								F3_SLT:  alu_func = ALU_SLT;
								F3_SLTU: alu_func = ALU_SLTU;
								F3_XOR:  alu_func = ALU_XOR;
								F3_SR:   alu_func = ALU_SRL;
								F3_OR:   alu_func = ALU_OR;
								default: alu_func = ALU_AND;
							endcase
						end
						FUNCT7_ALT: begin
							if (inst.funct3 == F3_ADD) alu_func = ALU_SUB;
							else if (inst.funct3 == F3_SR) alu_func = ALU_SRA;
							else illegal = `TRUE;
						end
						FUNCT7_MULDIV: begin
							ex_channel = MULT;
							// divide and remainder are not implemented
							case (inst.funct3)
								F3_MUL:    alu_func = ALU_MUL;
								F3_MULH:   alu_func = ALU_MULH;
								F3_MULHSU: alu_func = ALU_MULHSU;
								F3_MULHU:  alu_func = ALU_MULHU;
								default:   illegal  = `TRUE;
							endcase
						end
						default: illegal = `TRUE;
					endcase
				end
				OPC_SYSTEM: begin
					if (if_packet.inst == WFI_INST) begin
						halt = `TRUE;
					end else begin
						case (inst.funct3)
							F3_CSRRW, F3_CSRRS, F3_CSRRC: csr_op = `TRUE;
							default: illegal = `TRUE;
						endcase
					end
				end
				default: illegal = `TRUE;
			endcase

			// illegal words go out with no-op fields
			if (illegal) begin
				dest_sel   = DEST_NONE;
				opb_select = OPB_IS_RS2;
				alu_func   = ALU_ADD;
				ex_channel = ALU;
			end
		end
	end

endmodule

/* source/regfile.sv */
// architectural register file of the decode stage, read by rs1/rs2 and written at retire
`timescale 1ns/1ns
`include "rv_params.svh"

module regfile (
	input                         clock,
	input                         reset,
	input  [`REG_IDX_W-1:0]       rda_idx,
	input  [`REG_IDX_W-1:0]       rdb_idx,
	output logic [`XLEN-1:0]      rda_out,
	output logic [`XLEN-1:0]      rdb_out,
	input                         wr_en,
	input  [`REG_IDX_W-1:0]       wr_idx,
	input  [`XLEN-1:0]            wr_data
);

	// x0 has no storage
	logic [`XLEN-1:0] registers [1:`NUM_REGS-1];

	// zero reg first, then same-cycle write, then storage
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_IDX_W-1:0] idx);
		if (idx == `ZERO_REG) return '0;
		if (wr_en && (wr_idx == idx)) return wr_data;
		return registers[idx];
	endfunction

	always_comb begin
		rda_out = read_port(rda_idx);
		rdb_out = read_port(rdb_idx);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < `NUM_REGS; i++) registers[i] <= '0;
		end else if (wr_en && (wr_idx != `ZERO_REG)) begin
			registers[wr_idx] <= wr_data;
		end
	end

endmodule

/* source/id_stage.sv */
// unregistered decode stage, merges decoder fields, register reads and the destination mux
`timescale 1ns/1ns
`include "rv_params.svh"

module id_stage import pipe_pkg::*; (
	input                        clock,
	input                        reset,
	input  retire_packet_t       retire,
	input  if_id_packet_t        if_id,
	output id_ex_packet_t        decoded
);

	//////////////////////////////
	// decoder outputs
	//////////////////////////////

	opa_sel_e    opa_select;
	opb_sel_e    opb_select;
	dest_sel_e   dest_sel;
	alu_func_e   alu_func;
	ex_channel_e ex_channel;
	logic        rd_mem;
	logic        wr_mem;
	logic        cond_branch;
	logic        uncond_branch;
	logic        csr_op;
	logic        halt;
	logic        illegal;
	logic        valid;

	// source operand values
	logic [`XLEN-1:0] rs1_value;
	logic [`XLEN-1:0] rs2_value;

	decoder u_decoder (
		.if_packet     (if_id),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.dest_sel      (dest_sel),
		.alu_func      (alu_func),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.csr_op        (csr_op),
		.halt          (halt),
		.illegal       (illegal),
		.valid         (valid),
		.ex_channel    (ex_channel)
	);

	// retire port writes, rs fields read
	regfile u_regfile (
		.clock   (clock),
		.reset   (reset),
		.rda_idx (if_id.inst.rs1),
		.rdb_idx (if_id.inst.rs2),
		.rda_out (rs1_value),
		.rdb_out (rs2_value),
		.wr_en   (retire.valid),
		.wr_idx  (retire.dest_reg_idx),
		.wr_data (retire.dest_reg_value)
	);

	always_comb begin
		decoded.valid         = valid;
		decoded.inst          = if_id.inst;
		decoded.pc            = if_id.pc;
		decoded.npc           = if_id.npc;
		decoded.rs1_value     = rs1_value;
		decoded.rs2_value     = rs2_value;
		decoded.opa_select    = opa_select;
		decoded.opb_select    = opb_select;
		decoded.alu_func      = alu_func;
		decoded.rd_mem        = rd_mem;
		decoded.wr_mem        = wr_mem;
		decoded.cond_branch   = cond_branch;
		decoded.uncond_branch = uncond_branch;
		decoded.csr_op        = csr_op;
		decoded.halt          = halt;
		decoded.illegal       = illegal;
		decoded.ex_channel    = ex_channel;
		// stores, branches and no-ops target x0
		case (dest_sel)
			DEST_RD: decoded.dest_reg_idx = if_id.inst.rd;
			default: decoded.dest_reg_idx = `ZERO_REG;
		endcase
	end

endmodule

/* source/id_ex_reg.sv */
// ID/EX pipeline register between decode and dispatch, with stall hold and flush
`timescale 1ns/1ns
`include "rv_params.svh"

module id_ex_reg import pipe_pkg::*; (
	input                 clock,
	input                 reset,
	input                 stall,
	input                 flush,
	input  id_ex_packet_t d,
	output id_ex_packet_t q
);

	//////////////////////////////
	// state
	//////////////////////////////

	// valid is the only control bit
	logic          valid_q;
	// payload carries its own stale valid, replaced on output
	id_ex_packet_t payload_q;

	// flush wins over stall
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= `FALSE;
		end else if (!stall) begin
			valid_q <= d.valid;
		end
	end

	// payload just holds while stalled
	always_ff @(posedge clock) begin
		if (!stall) begin
			payload_q <= d;
		end
	end

	always_comb begin
		q       = payload_q;
		q.valid = valid_q;
	end

endmodule

/* source/id_top.sv */
// decode stage top, the combinational decode followed by the ID/EX register
`timescale 1ns/1ns

module id_top import pipe_pkg::*; (
	input                  clock,
	input                  reset,
	input                  stall,
	input                  flush,
	input  if_id_packet_t  if_id,
	input  retire_packet_t retire,
	output id_ex_packet_t  id_ex
);

	// decode result before the pipeline register
	id_ex_packet_t decoded;

	id_stage u_id_stage (
		.clock   (clock),
		.reset   (reset),
		.retire  (retire),
		.if_id   (if_id),
		.decoded (decoded)
	);

	// one cycle to the output
	id_ex_reg u_id_ex_reg (
		.clock (clock),
		.reset (reset),
		.stall (stall),
		.flush (flush),
		.d     (decoded),
		.q     (id_ex)
	);

endmodule

/* test/tb_id_top.sv */
// directed testbench for id_top, drives fetch and retire packets and checks the ID/EX packet
`timescale 1ns/1ns
`include "rv_params.svh"

module tb_id_top import isa_pkg::*, pipe_pkg::*; ();

	// upper bound on packets applied over all tests at two cycles each
	localparam int APPLY_COUNT = 70;
	localparam int CYCLES_PER_APPLY = 2;
	// reset, retire-only writes and stall/flush windows
	localparam int EXTRA_CYCLES = 40;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = APPLY_COUNT * CYCLES_PER_APPLY + EXTRA_CYCLES + MARGIN_CYCLES;

	localparam retire_packet_t NO_RETIRE = '0;
	// opcode 7'h7f is not a major opcode of RV32IM
	localparam logic [31:0] UNDEF_WORD = 32'h1234567f;

	// alu function by funct3 for the base group and the multiply group
	localparam alu_func_e BASE_ALU [0:7] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
	localparam alu_func_e MUL_ALU [0:3] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};

	logic           clock;
	logic           reset;
	logic           stall;
	logic           flush;
	if_id_packet_t  if_id;
	retire_packet_t retire;
	id_ex_packet_t  id_ex;

	logic [31:0]      lcg_state = 32'h3e198baa;
	// expected architectural register contents
	logic [`XLEN-1:0] reg_model [`NUM_REGS];
	string            current_test;

	id_top u_id_top (
		.clock  (clock),
		.reset  (reset),
		.stall  (stall),
		.flush  (flush),
		.if_id  (if_id),
		.retire (retire),
		.id_ex  (id_ex)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits of the lcg are the better mixed ones
	function automatic logic [`REG_IDX_W-1:0] random_index();
		logic [31:0] r;
		r = next_random();
		return r[20:16];
	endfunction

	function automatic logic [6:0] random_funct7();
		logic [31:0] r;
		r = next_random();
		return r[30:24];
	endfunction

	function automatic if_id_packet_t make_packet(input logic [6:0] f7,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
		input logic [4:0] rd, input opcode_e op);
		if_id_packet_t p;
		logic [31:0]   r;
		r = next_random();
		p.valid = `TRUE;
		p.inst = '{f7, rs2, rs1, f3, rd, op};
		p.pc = {r[31:2], 2'b00};
		p.npc = p.pc + 32'd4;
		return p;
	endfunction

	function automatic retire_packet_t make_retire(input logic [4:0] idx,
		input logic [`XLEN-1:0] value);
		retire_packet_t r;
		r.valid = `TRUE;
		r.dest_reg_idx = idx;
		r.dest_reg_value = value;
		return r;
	endfunction

	//////////////////////////////
	// reference decode
	//////////////////////////////

	function automatic id_ex_packet_t expected_decode(input if_id_packet_t p);
		id_ex_packet_t e;
		logic [2:0]    f3;
		logic [6:0]    f7;
		// all-zero is the no-op with RS1, RS2, ADD, the ALU channel, x0 and flags low
		e = '0;
		f3 = p.inst.funct3;
		f7 = p.inst.funct7;
		e.inst = p.inst;
		e.pc = p.pc;
		e.npc = p.npc;
		e.rs1_value = reg_model[p.inst.rs1];
		e.rs2_value = reg_model[p.inst.rs2];
		if (p.valid) begin
			case (p.inst.opcode)
				OPC_LUI: begin
					e.dest_reg_idx = p.inst.rd;
					e.opa_select = OPA_IS_ZERO;
					e.opb_select = OPB_IS_U_IMM;
				end
				OPC_AUIPC: begin
					e.dest_reg_idx = p.inst.rd;
					e.opa_select = OPA_IS_PC;
					e.opb_select = OPB_IS_U_IMM;
				end
				OPC_JAL: begin
					e.dest_reg_idx = p.inst.rd;
					e.opa_select = OPA_IS_PC;
					e.opb_select = OPB_IS_J_IMM;
					e.uncond_branch = `TRUE;
					e.ex_channel = BR;
				end
				OPC_JALR: begin
					e.dest_reg_idx = p.inst.rd;
					e.opb_select = OPB_IS_I_IMM;
					e.uncond_branch = `TRUE;
					e.ex_channel = BR;
				end
				OPC_BRANCH: begin
					e.opa_select = OPA_IS_PC;
					e.opb_select = OPB_IS_B_IMM;
					e.cond_branch = `TRUE;
					e.ex_channel = BR;
				end
				OPC_LOAD: begin
					e.dest_reg_idx = p.inst.rd;
					e.opb_select = OPB_IS_I_IMM;
					e.rd_mem = `TRUE;
					e.ex_channel = LD;
				end
				OPC_STORE: begin
					e.opb_select = OPB_IS_S_IMM;
					e.wr_mem = `TRUE;
					e.ex_channel = ST;
				end
				OPC_OP_IMM: begin
					e.dest_reg_idx = p.inst.rd;
					e.opb_select = OPB_IS_I_IMM;
					e.alu_func = BASE_ALU[f3];
					// shifts keep funct7 for the shift kind
					if (f3 == F3_SR && f7 == FUNCT7_ALT) e.alu_func = ALU_SRA;
					else if ((f3 == F3_SLL || f3 == F3_SR) && f7 != FUNCT7_BASE)
						e.illegal = `TRUE;
				end
				OPC_OP: begin
					e.dest_reg_idx = p.inst.rd;
					if (f7 == FUNCT7_BASE) begin
						e.alu_func = BASE_ALU[f3];
					end else if (f7 == FUNCT7_ALT && f3 == F3_ADD) begin
						e.alu_func = ALU_SUB;
					end else if (f7 == FUNCT7_ALT && f3 == F3_SR) begin
						e.alu_func = ALU_SRA;
					end else if (f7 == FUNCT7_MULDIV && !f3[2]) begin
						e.alu_func = MUL_ALU[f3[1:0]];
						e.ex_channel = MULT;
					end else begin
						e.illegal = `TRUE;
					end
				end
				OPC_SYSTEM: begin
					if (p.inst == WFI_INST) e.halt = `TRUE;
					else if (f3 == F3_CSRRW || f3 == F3_CSRRS || f3 == F3_CSRRC) e.csr_op = `TRUE;
					else e.illegal = `TRUE;
				end
				default: e.illegal = `TRUE;
			endcase
			// an illegal word carries no destination and no alu work
			if (e.illegal) begin
				e.dest_reg_idx = `ZERO_REG;
				e.opb_select = OPB_IS_RS2;
				e.alu_func = ALU_ADD;
				e.ex_channel = ALU;
			end
		end
		e.valid = p.valid & ~e.illegal;
		return e;
	endfunction

	//////////////////////////////
	// checks and drivers
	//////////////////////////////

	task automatic check(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected %h, actual %h", current_test, field,
				expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_packet(input id_ex_packet_t e);
		check("valid", 32'(e.valid), 32'(id_ex.valid));
		check("inst", 32'(e.inst), 32'(id_ex.inst));
		check("pc", e.pc, id_ex.pc);
		check("npc", e.npc, id_ex.npc);
		check("rs1_value", e.rs1_value, id_ex.rs1_value);
		check("rs2_value", e.rs2_value, id_ex.rs2_value);
		check("opa_select", 32'(e.opa_select), 32'(id_ex.opa_select));
		check("opb_select", 32'(e.opb_select), 32'(id_ex.opb_select));
		check("alu_func", 32'(e.alu_func), 32'(id_ex.alu_func));
		check("dest_reg_idx", 32'(e.dest_reg_idx), 32'(id_ex.dest_reg_idx));
		check("rd_mem", 32'(e.rd_mem), 32'(id_ex.rd_mem));
		check("wr_mem", 32'(e.wr_mem), 32'(id_ex.wr_mem));
		check("cond_branch", 32'(e.cond_branch), 32'(id_ex.cond_branch));
		check("uncond_branch", 32'(e.uncond_branch), 32'(id_ex.uncond_branch));
		check("csr_op", 32'(e.csr_op), 32'(id_ex.csr_op));
		check("halt", 32'(e.halt), 32'(id_ex.halt));
		check("illegal", 32'(e.illegal), 32'(id_ex.illegal));
		check("ex_channel", 32'(e.ex_channel), 32'(id_ex.ex_channel));
	endtask

	// present one packet with an optional same-cycle retire and check after the capture edge
	task automatic apply(input if_id_packet_t p, input retire_packet_t r);
		id_ex_packet_t e;
		if (r.valid && r.dest_reg_idx != `ZERO_REG) reg_model[r.dest_reg_idx] = r.dest_reg_value;
		e = expected_decode(p);
		@(posedge clock);
		if_id <= p;
		retire <= r;
		@(posedge clock);
		retire <= NO_RETIRE;
		@(negedge clock);
		check_packet(e);
	endtask

	task automatic write_register(input logic [4:0] idx, input logic [`XLEN-1:0] value);
		@(posedge clock);
		retire <= make_retire(idx, value);
		if (idx != `ZERO_REG) reg_model[idx] = value;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_alu_decode();
		logic [6:0] f7;
		current_test = "alu_decode";
		for (int f3 = 0; f3 < 8; f3++) begin
			apply(make_packet(FUNCT7_BASE, random_index(), random_index(), 3'(f3),
				random_index(), OPC_OP), NO_RETIRE);
			// the immediate fills funct7 except on shifts
			f7 = (f3 == 1 || f3 == 5) ? FUNCT7_BASE : random_funct7();
			apply(make_packet(f7, random_index(), random_index(), 3'(f3),
				random_index(), OPC_OP_IMM), NO_RETIRE);
			if (f3 < 4) apply(make_packet(FUNCT7_MULDIV, random_index(), random_index(),
				3'(f3), random_index(), OPC_OP), NO_RETIRE);
		end
		apply(make_packet(FUNCT7_ALT, random_index(), random_index(), F3_ADD,
			random_index(), OPC_OP), NO_RETIRE);
		apply(make_packet(FUNCT7_ALT, random_index(), random_index(), F3_SR,
			random_index(), OPC_OP), NO_RETIRE);
		apply(make_packet(FUNCT7_ALT, random_index(), random_index(), F3_SR,
			random_index(), OPC_OP_IMM), NO_RETIRE);
	endtask

	task automatic test_control_decode();
		logic [2:0] load_f3 [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
		logic [2:0] store_f3 [3] = '{F3_SB, F3_SH, F3_SW};
		logic [2:0] branch_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		current_test = "control_decode";
		foreach (load_f3[i]) apply(make_packet(random_funct7(), random_index(),
			random_index(), load_f3[i], random_index(), OPC_LOAD), NO_RETIRE);
		// stores and branches must name x0 as destination
		foreach (store_f3[i]) apply(make_packet(random_funct7(), random_index(),
			random_index(), store_f3[i], random_index(), OPC_STORE), NO_RETIRE);
		foreach (branch_f3[i]) apply(make_packet(random_funct7(), random_index(),
			random_index(), branch_f3[i], random_index(), OPC_BRANCH), NO_RETIRE);
		apply(make_packet(random_funct7(), random_index(), random_index(), F3_ADD,
			random_index(), OPC_JAL), NO_RETIRE);
		apply(make_packet(random_funct7(), random_index(), random_index(), F3_ADD,
			random_index(), OPC_JALR), NO_RETIRE);
		apply(make_packet(random_funct7(), random_index(), random_index(), F3_XOR,
			random_index(), OPC_LUI), NO_RETIRE);
		apply(make_packet(random_funct7(), random_index(), random_index(), F3_OR,
			random_index(), OPC_AUIPC), NO_RETIRE);
	endtask

	task automatic test_special_cases();
		if_id_packet_t p;
		current_test = "special_cases";
		p = make_packet(FUNCT7_BASE, 5'd0, 5'd0, F3_ADD, 5'd0, OPC_SYSTEM);
		p.inst = WFI_INST;
		apply(p, NO_RETIRE);
		for (int f3 = 1; f3 < 4; f3++) apply(make_packet(random_funct7(), random_index(),
			random_index(), 3'(f3), random_index(), OPC_SYSTEM), NO_RETIRE);
		p.inst = UNDEF_WORD;
		apply(p, NO_RETIRE);
		// a bubble from fetch
		p = make_packet(FUNCT7_BASE, random_index(), random_index(), F3_ADD,
			random_index(), OPC_OP);
		p.valid = `FALSE;
		apply(p, NO_RETIRE);
	endtask

	task automatic test_register_file();
		logic [4:0] written [8];
		logic [4:0] idx;
		current_test = "register_file";
		foreach (written[i]) begin
			written[i] = random_index();
			write_register(written[i], next_random());
		end
		@(posedge clock);
		retire <= NO_RETIRE;
		foreach (written[i]) apply(make_packet(FUNCT7_BASE, written[(i + 1) % 8],
			written[i], F3_ADD, random_index(), OPC_OP), NO_RETIRE);
		// x0 ignores the write in bypass and afterwards
		apply(make_packet(FUNCT7_BASE, 5'd0, 5'd0, F3_ADD, random_index(), OPC_OP),
			make_retire(5'd0, next_random()));
		apply(make_packet(FUNCT7_BASE, 5'd0, 5'd0, F3_ADD, random_index(), OPC_OP),
			NO_RETIRE);
		idx = random_index() | 5'd1;
		apply(make_packet(FUNCT7_BASE, idx, idx, F3_ADD, random_index(), OPC_OP),
			make_retire(idx, next_random()));
	endtask

	task automatic test_pipeline_control();
		if_id_packet_t p;
		id_ex_packet_t held;
		current_test = "pipeline_control";
		// a valid packet sits in the register and stays on the input through reset
		p = make_packet(FUNCT7_BASE, random_index(), random_index(), F3_ADD,
			random_index(), OPC_OP);
		apply(p, NO_RETIRE);
		@(posedge clock);
		reset <= `TRUE;
		repeat (2) @(posedge clock);
		reset <= `FALSE;
		foreach (reg_model[i]) reg_model[i] = '0;
		@(negedge clock);
		check("valid after reset", 32'd0, 32'(id_ex.valid));
		p = make_packet(FUNCT7_BASE, random_index(), random_index(), F3_XOR,
			random_index(), OPC_OP);
		apply(p, NO_RETIRE);
		held = expected_decode(p);
		// the input changes under stall while the output holds
		@(posedge clock);
		stall <= `TRUE;
		if_id <= make_packet(random_funct7(), random_index(), random_index(), F3_LW,
			random_index(), OPC_LOAD);
		repeat (3) @(posedge clock);
		@(negedge clock);
		check_packet(held);
		@(posedge clock);
		flush <= `TRUE;
		@(posedge clock);
		flush <= `FALSE;
		@(negedge clock);
		check("valid after flush under stall", 32'd0, 32'(id_ex.valid));
		p = make_packet(FUNCT7_MULDIV, random_index(), random_index(), F3_MULH,
			random_index(), OPC_OP);
		held = expected_decode(p);
		@(posedge clock);
		stall <= `FALSE;
		if_id <= p;
		@(posedge clock);
		@(negedge clock);
		check_packet(held);
	endtask

	//////////////////////////////
	// sequence and watchdog
	//////////////////////////////

	initial begin
		reset = `TRUE;
		stall = `FALSE;
		flush = `FALSE;
		if_id = '0;
		retire = NO_RETIRE;
		foreach (reg_model[i]) reg_model[i] = '0;
		repeat (2) @(posedge clock);
		reset <= `FALSE;
		test_pipeline_control();
		test_alu_decode();
		test_control_decode();
		test_special_cases();
		test_register_file();
		$display("sim passed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1);
	end

endmodule

/* sources.f */
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/decoder.sv
source/regfile.sv
source/id_stage.sv
source/id_ex_reg.sv
source/id_top.sv
test/tb_id_top.sv

/* Makefile */
# Verilator build of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= tb_id_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
